//--- Bender.yml
package:
  name: red_offload

sources:
  - files:
      - red_pkg.sv
      - red_pair_ctrl.sv
      - red_alu_pipe.sv
      - red_result_assembler.sv
      - red_out_arbiter.sv
      - red_offload_top.sv
  - target: test
    files:
      - tb_red_offload.sv

//--- list.f
red_pkg.sv
red_pair_ctrl.sv
red_alu_pipe.sv
red_result_assembler.sv
red_out_arbiter.sv
red_offload_top.sv
tb_red_offload.sv

//--- red_alu_pipe.sv
// Pipelined ADD/MAX reduction unit with whole-pipe freeze on back-pressure
module red_alu_pipe #(
    parameter int unsigned PIPE_DEPTH = red_pkg::PIPE_DEPTH_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    // Operand pair
    input  red_pkg::red_operands_t  op_i,
    input  logic                    op_valid_i,
    output logic                    op_ready_o,
    // Reduced result
    output red_pkg::red_result_t    res_o,
    output logic                    res_valid_o,
    input  logic                    res_ready_i
);

    red_pkg::red_data_t     alu_res;
    red_pkg::red_data_t     data_q [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0]  vld_q;
    logic                   stall;

    // First stage arithmetic
    always_comb begin
        case (op_i.op)
            // Unsigned compare
            red_pkg::RED_MAX: alu_res = (op_i.opa > op_i.opb) ? op_i.opa : op_i.opb;
            // Wrapped 16-bit sum
            default:          alu_res = op_i.opa + op_i.opb;
        endcase
    end

    // Output held and not taken, so nothing may move
    assign stall      = res_valid_o & ~res_ready_i;
    assign op_ready_o = ~stall;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else if (!stall) begin
            vld_q[0] <= op_valid_i;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            data_q[0] <= alu_res;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    // Last stage drives the result
    assign res_valid_o = vld_q[PIPE_DEPTH-1];
    assign res_o.data  = data_q[PIPE_DEPTH-1];

endmodule

//--- red_offload_top.sv
// Reduction offload top level with pair controller, ALU pipe,
// result assembler and output arbiter
module red_offload_top #(
    parameter int unsigned PIPE_DEPTH = red_pkg::PIPE_DEPTH_DEF,
    parameter int unsigned META_DEPTH = red_pkg::META_DEPTH_DEF
) (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  red_pkg::red_flit_t [red_pkg::NUM_ROUTES_DEF-1:0]  in_flit_i,
    input  red_pkg::route_mask_t                              in_valid_i,
    output red_pkg::route_mask_t                              in_ready_o,
    output red_pkg::red_flit_t                                out_flit_o,
    output logic                                              out_valid_o,
    input  logic                                              out_ready_i
);

    // Controller to ALU
    red_pkg::red_operands_t op;
    logic                   op_valid;
    logic                   op_ready;
    // Controller to header queue
    red_pkg::red_hdr_t      hdr;
    logic                   meta_full;
    logic                   meta_empty;
    // ALU to assembler
    red_pkg::red_result_t   res;
    logic                   res_valid;
    logic                   res_ready;
    // Assembler and bypass to arbiter
    red_pkg::red_flit_t     red_flit;
    logic                   red_valid;
    logic                   red_ready;
    red_pkg::red_flit_t     byp_flit;
    logic                   byp_valid;
    logic                   byp_ready;

    red_pair_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_flit_i    (in_flit_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .op_o         (op),
        .op_valid_o   (op_valid),
        .op_ready_i   (op_ready),
        .hdr_o        (hdr),
        .meta_full_i  (meta_full),
        .meta_empty_i (meta_empty),
        .byp_flit_o   (byp_flit),
        .byp_valid_o  (byp_valid),
        .byp_ready_i  (byp_ready)
    );

    red_alu_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_alu (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .op_i        (op),
        .op_valid_i  (op_valid),
        .op_ready_o  (op_ready),
        .res_o       (res),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready)
    );

    // Header push on the issue handshake keeps queue order equal to ALU order
    red_result_assembler #(
        .META_DEPTH (META_DEPTH)
    ) u_asm (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hdr_i       (hdr),
        .push_i      (op_valid & op_ready),
        .full_o      (meta_full),
        .empty_o     (meta_empty),
        .res_i       (res),
        .res_valid_i (res_valid),
        .res_ready_o (res_ready),
        .flit_o      (red_flit),
        .valid_o     (red_valid),
        .ready_i     (red_ready)
    );

    red_out_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .byp_flit_i  (byp_flit),
        .byp_valid_i (byp_valid),
        .byp_ready_o (byp_ready),
        .red_flit_i  (red_flit),
        .red_valid_i (red_valid),
        .red_ready_o (red_ready),
        .out_flit_o  (out_flit_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

//--- red_out_arbiter.sv
// Two-way round-robin arbiter of bypass and reduced streams onto the output,
// with the grant held under back-pressure
module red_out_arbiter (
    input  logic                clk_i,
    input  logic                rst_i,
    // Bypass stream
    input  red_pkg::red_flit_t  byp_flit_i,
    input  logic                byp_valid_i,
    output logic                byp_ready_o,
    // Reduced stream
    input  red_pkg::red_flit_t  red_flit_i,
    input  logic                red_valid_i,
    output logic                red_ready_o,
    // Output port
    output red_pkg::red_flit_t  out_flit_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    // Grant 0 selects bypass and grant 1 selects reduced
    logic last_q;
    logic hold_vld_q;
    logic hold_sel_q;
    logic gnt;

    always_comb begin
        if (hold_vld_q) begin
            // Offer stays on the same input until it is taken
            gnt = hold_sel_q;
        end else if (byp_valid_i && red_valid_i) begin
            gnt = ~last_q;
        end else begin
            gnt = red_valid_i;
        end
    end

    assign out_valid_o = gnt ? red_valid_i : byp_valid_i;
    assign out_flit_o  = gnt ? red_flit_i : byp_flit_i;
    assign byp_ready_o = out_ready_i & ~gnt;
    assign red_ready_o = out_ready_i & gnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q     <= 1'b0;
            hold_vld_q <= 1'b0;
            hold_sel_q <= 1'b0;
        end else if (out_valid_o && out_ready_i) begin
            // Rotate priority after each transfer
            last_q     <= gnt;
            hold_vld_q <= 1'b0;
        end else if (out_valid_o) begin
            hold_vld_q <= 1'b1;
            hold_sel_q <= gnt;
        end
    end

endmodule

//--- red_pair_ctrl.sv
// Pair selection FSM with lock register, operand issue to the ALU
// and header-only bypass of SELECT flits
module red_pair_ctrl (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    // Input routes
    input  red_pkg::red_flit_t [red_pkg::NUM_ROUTES_DEF-1:0]  in_flit_i,
    input  red_pkg::route_mask_t                              in_valid_i,
    output red_pkg::route_mask_t                              in_ready_o,
    // Operand issue towards the ALU
    output red_pkg::red_operands_t                            op_o,
    output logic                                              op_valid_o,
    input  logic                                              op_ready_i,
    // Header pushed into the metadata queue on issue
    output red_pkg::red_hdr_t                                 hdr_o,
    input  logic                                              meta_full_i,
    input  logic                                              meta_empty_i,
    // Bypass stream
    output red_pkg::red_flit_t                                byp_flit_o,
    output logic                                              byp_valid_o,
    input  logic                                              byp_ready_i
);

    typedef enum logic {
        IDLE,
        LOCKED
    } state_e;

    state_e                 state_q, state_d;
    // Locked pair with the lower index in entry 0
    red_pkg::route_idx_t    sel_q [2];
    red_pkg::route_idx_t    cand_idx [2];
    logic                   first_found;
    logic                   pair_found;

    red_pkg::red_flit_t     first_flit;
    red_pkg::red_flit_t     second_flit;
    logic                   locked;
    logic                   is_select;
    logic                   exp_all_valid;
    logic                   issue_hs;
    logic                   byp_hs;
    red_pkg::route_mask_t   pair_mask;

    // Search the two lowest-indexed valid inputs
    always_comb begin
        first_found = 1'b0;
        pair_found  = 1'b0;
        cand_idx[0] = '0;
        cand_idx[1] = '0;
        for (int i = 0; i < red_pkg::NUM_ROUTES_DEF; i++) begin
            if (in_valid_i[i]) begin
                if (!first_found) begin
                    cand_idx[0] = red_pkg::route_idx_t'(i);
                    first_found = 1'b1;
                end else if (!pair_found) begin
                    cand_idx[1] = red_pkg::route_idx_t'(i);
                    pair_found  = 1'b1;
                end
            end
        end
    end

    assign locked      = (state_q == LOCKED);
    assign first_flit  = in_flit_i[sel_q[0]];
    assign second_flit = in_flit_i[sel_q[1]];
    assign is_select   = (first_flit.hdr.op == red_pkg::RED_SELECT);

    // All routes named by the SELECT header must be present together
    assign exp_all_valid = ((in_valid_i & first_flit.hdr.in_exp) == first_flit.hdr.in_exp);

    // Reduction issue only with room left in the header queue
    assign op_valid_o = locked && !is_select && !meta_full_i;
    assign op_o.opa   = first_flit.data;
    assign op_o.opb   = second_flit.data;
    assign op_o.op    = first_flit.hdr.op;
    assign hdr_o      = first_flit.hdr;

    // Bypass waits until every earlier reduction has left the output
    assign byp_valid_o = locked && is_select && meta_empty_i && exp_all_valid;
    assign byp_flit_o  = first_flit;

    assign issue_hs = op_valid_o & op_ready_i;
    assign byp_hs   = byp_valid_o & byp_ready_i;

    assign pair_mask = (red_pkg::route_mask_t'(1) << sel_q[0])
                     | (red_pkg::route_mask_t'(1) << sel_q[1]);

    // Acknowledge the pair on issue, or every masked route on bypass
    assign in_ready_o = ({red_pkg::NUM_ROUTES_DEF{issue_hs}} & pair_mask)
                      | ({red_pkg::NUM_ROUTES_DEF{byp_hs}} & first_flit.hdr.in_exp);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pair_found) begin
                    state_d = LOCKED;
                end
            end
            LOCKED: begin
                // Lock is released in the handshake cycle
                if (issue_hs || byp_hs) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= IDLE;
            sel_q[0] <= '0;
            sel_q[1] <= '0;
        end else begin
            state_q <= state_d;
            // Indices only load when a new pair is taken
            if (state_q == IDLE && pair_found) begin
                sel_q[0] <= cand_idx[0];
                sel_q[1] <= cand_idx[1];
            end
        end
    end

endmodule

//--- red_pkg.sv
// Shared widths, route and payload types, operation encoding and flit structs
// for the reduction offload unit
package red_pkg;

    // Number of input routes of the router port
    localparam int unsigned NUM_ROUTES_DEF = 4;

    // Payload width carried in every flit
    localparam int unsigned RED_DATA_W = 16;

    // ALU stages, one per cycle of latency
    localparam int unsigned PIPE_DEPTH_DEF = 3;

    // Header queue must cover all items in flight plus the output stage
    localparam int unsigned META_DEPTH_DEF = PIPE_DEPTH_DEF + 2;

    // Width of a route index
    localparam int unsigned ROUTE_IDX_W = (NUM_ROUTES_DEF > 1) ? $clog2(NUM_ROUTES_DEF) : 1;

    // Payload data
    typedef logic [RED_DATA_W-1:0] red_data_t;

    // One bit per route, used for input and output direction masks
    typedef logic [NUM_ROUTES_DEF-1:0] route_mask_t;

    // Index of a single route
    typedef logic [ROUTE_IDX_W-1:0] route_idx_t;

    // Operation carried in the header
    // SELECT marks a header-only flit that is forwarded once
    typedef enum logic [1:0] {
        RED_ADD    = 2'd0,
        RED_MAX    = 2'd1,
        RED_SELECT = 2'd2
    } red_op_e;

    // Header fields
    typedef struct packed {
        red_op_e     op;
        // Output directions of the result
        route_mask_t out_dir;
        // Inputs taking part in the operation
        route_mask_t in_exp;
    } red_hdr_t;

    // Flit as seen on the inputs, the bypass and the output
    typedef struct packed {
        red_hdr_t  hdr;
        red_data_t data;
    } red_flit_t;

    // Both operands and the operation, issued together to the ALU
    typedef struct packed {
        red_data_t opa;
        red_data_t opb;
        red_op_e   op;
    } red_operands_t;

    // Reduced data leaving the ALU
    typedef struct packed {
        red_data_t data;
    } red_result_t;

endpackage

//--- red_result_assembler.sv
// Circular header queue that rejoins stored headers with ALU results
// on their way to the output arbiter
module red_result_assembler #(
    parameter int unsigned META_DEPTH = red_pkg::META_DEPTH_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Header push on ALU issue
    input  red_pkg::red_hdr_t     hdr_i,
    input  logic                  push_i,
    output logic                  full_o,
    output logic                  empty_o,
    // Result from the ALU
    input  red_pkg::red_result_t  res_i,
    input  logic                  res_valid_i,
    output logic                  res_ready_o,
    // Joined flit towards the arbiter
    output red_pkg::red_flit_t    flit_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    localparam int unsigned PTR_W = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(META_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    red_pkg::red_hdr_t  mem [META_DEPTH];
    ptr_t               wr_ptr_q;
    ptr_t               rd_ptr_q;
    cnt_t               count_q;
    logic               pop;

    assign full_o  = (count_q == cnt_t'(META_DEPTH));
    assign empty_o = (count_q == '0);

    // Results come back in issue order, so the head header always belongs to them
    assign valid_o     = res_valid_i;
    assign res_ready_o = ready_i;
    assign flit_o.hdr  = mem[rd_ptr_q];
    assign flit_o.data = res_i.data;

    // Pop together with the output handshake
    assign pop = valid_o & ready_i;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= hdr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(META_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(META_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Occupancy tracks push and pop in the same cycle
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- tb_red_offload.sv
// Testbench for the reduction offload unit with LFSR stimulus,
// scoreboard queue, concurrent checks and watchdog
module tb_red_offload;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned PIPE_DEPTH = 3;
    localparam int unsigned META_DEPTH = 5;
    localparam int unsigned N = red_pkg::NUM_ROUTES_DEF;
    localparam int unsigned NUM_DIRECTED = 6;
    localparam int unsigned NUM_RANDOM = 60;
    localparam int unsigned NUM_OPS = NUM_DIRECTED + NUM_RANDOM;
    localparam int unsigned DRAIN_MAX = 200;
    // Per operation budget in cycles of 4 ns plus a fixed margin
    localparam int unsigned TIMEOUT_NS = NUM_OPS * (PIPE_DEPTH + 10) * 4 + 2000;

    logic                             clk_i;
    logic                             rst_i;
    red_pkg::red_flit_t [N-1:0]       in_flit_i;
    red_pkg::route_mask_t             in_valid_i;
    red_pkg::route_mask_t             in_ready_o;
    red_pkg::red_flit_t               out_flit_o;
    logic                             out_valid_o;
    logic                             out_ready_i;

    // Scoreboard in issue order with its head mirrored for the checks
    red_pkg::red_flit_t               exp_q [$];
    red_pkg::red_flit_t               exp_head;
    int unsigned                      exp_count;
    // Operation waiting to be applied at the next falling edge
    red_pkg::red_flit_t [N-1:0]       pend_flits;
    red_pkg::route_mask_t             pend_mask;
    red_pkg::red_flit_t               pend_exp;
    logic                             pend_load;
    // Routes of the operation on the inputs
    red_pkg::route_mask_t             cur_mask;
    // Handshakes seen just before the coming rising edge
    red_pkg::route_mask_t             in_acked;
    logic                             out_hs;
    logic                             rdy_random;
    logic [31:0]                      lfsr_q;
    string                            test_name;

    red_offload_top #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .META_DEPTH (META_DEPTH)
    ) u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_flit_i   (in_flit_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_flit_o  (out_flit_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    always #2 clk_i = ~clk_i;

    task automatic report_value_error(string name, red_pkg::red_flit_t exp_flit,
                                      red_pkg::red_flit_t act_flit);
        $display("[ERROR] %s: expected %h, actual %h", name, exp_flit, act_flit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Output flit mismatch");
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Check failed");
    endtask

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // Wrapped sum or unsigned maximum
    function automatic red_pkg::red_data_t expected_data(red_pkg::red_op_e op,
                                                         red_pkg::red_data_t a,
                                                         red_pkg::red_data_t b);
        if (op == red_pkg::RED_MAX) begin
            return (a >= b) ? a : b;
        end
        return red_pkg::red_data_t'(a + b);
    endfunction

    function automatic red_pkg::red_flit_t make_flit(red_pkg::red_op_e op,
                                                     red_pkg::route_mask_t in_exp,
                                                     red_pkg::red_data_t data);
        red_pkg::red_flit_t f;
        f.hdr.op      = op;
        f.hdr.out_dir = red_pkg::route_mask_t'(take_bits(N));
        f.hdr.in_exp  = in_exp;
        f.data        = data;
        return f;
    endfunction

    // One clock cycle with inputs applied on the falling edge
    task automatic step();
        @(negedge clk_i);
        if (out_hs) begin
            void'(exp_q.pop_front());
        end
        // Routes taken at the last rising edge go idle
        in_valid_i = in_valid_i & ~in_acked;
        if (pend_load) begin
            in_flit_i  = pend_flits;
            in_valid_i = pend_mask;
            cur_mask   = pend_mask;
            exp_q.push_back(pend_exp);
            pend_load  = 1'b0;
        end
        exp_count   = exp_q.size();
        exp_head    = (exp_count != 0) ? exp_q[0] : '0;
        out_ready_i = !rdy_random || (take_bits(1) != 0);
        // Outputs are settled well before the next rising edge
        #1;
        out_hs   = out_valid_o & out_ready_i;
        in_acked = in_ready_o & in_valid_i;
    endtask

    task automatic send_op(red_pkg::red_flit_t [N-1:0] flits, red_pkg::route_mask_t mask,
                           red_pkg::red_flit_t exp_flit);
        // Previous operation fully consumed first
        while (in_valid_i != '0 || in_acked != '0) begin
            step();
        end
        pend_flits = flits;
        pend_mask  = mask;
        pend_exp   = exp_flit;
        pend_load  = 1'b1;
        step();
    endtask

    task automatic pair_op(red_pkg::red_op_e op, int unsigned lo, int unsigned hi,
                           red_pkg::red_data_t a, red_pkg::red_data_t b);
        red_pkg::red_flit_t [N-1:0] flits;
        red_pkg::route_mask_t       mask;
        red_pkg::red_flit_t         exp_flit;
        mask      = (red_pkg::route_mask_t'(1) << lo) | (red_pkg::route_mask_t'(1) << hi);
        flits     = '0;
        flits[lo] = make_flit(op, mask, a);
        flits[hi] = make_flit(op, mask, b);
        // Lower-indexed header travels with the result
        exp_flit.hdr  = flits[lo].hdr;
        exp_flit.data = expected_data(op, a, b);
        send_op(flits, mask, exp_flit);
    endtask

    task automatic select_op(red_pkg::route_mask_t mask);
        red_pkg::red_flit_t [N-1:0] flits;
        int unsigned                first;
        logic                       found;
        flits = '0;
        first = 0;
        found = 1'b0;
        for (int unsigned r = 0; r < N; r++) begin
            if (mask[r]) begin
                flits[r] = make_flit(red_pkg::RED_SELECT, mask,
                                     red_pkg::red_data_t'(take_bits(red_pkg::RED_DATA_W)));
                if (!found) begin
                    first = r;
                    found = 1'b1;
                end
            end
        end
        // Lowest masked flit leaves unchanged
        send_op(flits, mask, flits[first]);
    endtask

    task automatic random_op();
        logic [1:0]           kind;
        int unsigned          ia;
        int unsigned          ib;
        red_pkg::route_mask_t mask;
        kind = 2'(take_bits(2));
        ia   = take_bits(red_pkg::ROUTE_IDX_W);
        ib   = take_bits(red_pkg::ROUTE_IDX_W);
        if (ib == ia) begin
            ib = (ia + 1) % N;
        end
        if (kind == 2'd3) begin
            mask = red_pkg::route_mask_t'(take_bits(N)) | (red_pkg::route_mask_t'(1) << ia)
                 | (red_pkg::route_mask_t'(1) << ib);
            select_op(mask);
        end else if (kind == 2'd2) begin
            pair_op(red_pkg::RED_MAX, (ia < ib) ? ia : ib, (ia < ib) ? ib : ia,
                    red_pkg::red_data_t'(take_bits(red_pkg::RED_DATA_W)),
                    red_pkg::red_data_t'(take_bits(red_pkg::RED_DATA_W)));
        end else begin
            pair_op(red_pkg::RED_ADD, (ia < ib) ? ia : ib, (ia < ib) ? ib : ia,
                    red_pkg::red_data_t'(take_bits(red_pkg::RED_DATA_W)),
                    red_pkg::red_data_t'(take_bits(red_pkg::RED_DATA_W)));
        end
    endtask

    // Idle outputs in the first cycle out of reset
    chk_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (!out_valid_o && in_ready_o == '0))
        else report_failure("Output valid or input ready was high right after reset");

    chk_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && out_ready_i) |-> (exp_count != 0))
        else report_failure("An output flit was sent while none was expected");

    chk_data: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && out_ready_i && exp_count != 0) |-> (out_flit_o == exp_head))
        else report_value_error(test_name, $sampled(exp_head), $sampled(out_flit_o));

    chk_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_flit_o)))
        else report_failure("Output flit changed or dropped while stalled");

    // All routes of an operation are acknowledged in the same cycle
    chk_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        (in_ready_o != '0) |-> (in_ready_o == cur_mask))
        else report_failure("Input ready did not match the routes of the current operation");

    initial begin
        #(TIMEOUT_NS * 1ns);
        report_failure("Run timed out before all expected flits were seen");
    end

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        in_flit_i   = '0;
        in_valid_i  = '0;
        out_ready_i = 1'b0;
        pend_flits  = '0;
        pend_mask   = '0;
        pend_exp    = '0;
        pend_load   = 1'b0;
        cur_mask    = '0;
        in_acked    = '0;
        out_hs      = 1'b0;
        rdy_random  = 1'b0;
        exp_head    = '0;
        exp_count   = 0;
        lfsr_q      = 32'd99956;
        test_name   = "reset";
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        test_name = "add_pair";
        pair_op(red_pkg::RED_ADD, 1, 3, 16'hFFF0, 16'h0025);
        pair_op(red_pkg::RED_ADD, 0, 1, 16'h1234, 16'h4321);
        test_name = "max_pair";
        pair_op(red_pkg::RED_MAX, 0, 2, 16'h8001, 16'h7FFF);
        pair_op(red_pkg::RED_MAX, 2, 3, 16'h0010, 16'h0100);
        test_name = "select_bypass";
        select_op(4'b1011);
        select_op(4'b1110);

        // Mixed traffic under random output stalls
        test_name  = "random_mix";
        rdy_random = 1'b1;
        for (int unsigned n = 0; n < NUM_RANDOM; n++) begin
            random_op();
        end
        for (int unsigned w = 0; w < DRAIN_MAX; w++) begin
            if (exp_q.size() != 0 || in_valid_i != '0) begin
                step();
            end
        end
        // Extra cycles so a duplicate output would still be caught
        repeat (PIPE_DEPTH + 4) step();

        if (exp_q.size() == 0 && in_valid_i == '0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("Scoreboard still holds expected flits at the end of the run");
        end
    end

endmodule
